/* design/decode_pkg.sv */
// shared types, instruction encodings and helper functions for the decode buffer
// every design module and the testbench import this with a wildcard import

package decode_pkg;

	// ============================================================
	// types
	// ============================================================

	localparam int INSN_W = 40;

	typedef logic [INSN_W-1:0] insn_t;
	typedef logic [4:0] reg_spec_t;
	typedef logic [7:0] cause_t;
	typedef logic [3:0] irq_lvl_t;
	typedef logic [1:0] ic_fault_t;
	typedef logic [4:0] cb_addr_t;
	typedef logic [5:0] opcode_t;
	typedef logic [4:0] funct_t;
	typedef logic [4:0] lsm_cnt_t;

	// field positions (lsb) inside an instruction
	localparam int OPC_LSB = 0;
	localparam int RD_LSB = 8;
	localparam int XIDX_LSB = 13;
	localparam int RS2_LSB = 18;
	localparam int CNT_LSB = 23;
	localparam int FN_LSB = 35;
	// interrupt instruction only
	localparam int INT_LVL_LSB = 8;
	localparam int INT_CAUSE_LSB = 16;

	// ============================================================
	// encodings
	// ============================================================

	localparam opcode_t OP_BRK = 6'h00;
	localparam opcode_t OP_INT = 6'h01;
	localparam opcode_t OP_LSM = 6'h2A;
	localparam opcode_t OP_BMISC = 6'h3A;
	localparam opcode_t OP_NOP = 6'h3D;

	localparam funct_t FN_PFI = 5'h11;
	localparam funct_t FN_EXEC = 5'h0E;

	// fetch fault codes from the icache
	localparam ic_fault_t IC_NONE = 2'd0;
	localparam ic_fault_t IC_TLB = 2'd1;
	localparam ic_fault_t IC_EXF = 2'd2;
	localparam ic_fault_t IC_IBE = 2'd3;

	// trap causes carried by fault-trap instructions
	localparam cause_t FLT_TLB = 8'd35;
	localparam cause_t FLT_EXF = 8'd36;
	localparam cause_t FLT_IBE = 8'd37;

	// only the opcode field is set
	localparam insn_t NOP_INSN = insn_t'(OP_NOP);

	// ============================================================
	// helpers
	// ============================================================

	function automatic opcode_t get_opcode(input insn_t insn);
		return insn[OPC_LSB +: $bits(opcode_t)];
	endfunction

	function automatic funct_t get_funct(input insn_t insn);
		return insn[FN_LSB +: $bits(funct_t)];
	endfunction

	function automatic cb_addr_t get_exec_idx(input insn_t insn);
		return insn[XIDX_LSB +: $bits(cb_addr_t)];
	endfunction

	function automatic lsm_cnt_t get_lsm_cnt(input insn_t insn);
		return insn[CNT_LSB +: $bits(lsm_cnt_t)];
	endfunction

	function automatic logic is_pfi(input insn_t insn);
		return (get_opcode(insn) == OP_BRK) && (get_funct(insn) == FN_PFI);
	endfunction

	function automatic logic is_exec(input insn_t insn);
		return (get_opcode(insn) == OP_BMISC) && (get_funct(insn) == FN_EXEC);
	endfunction

	function automatic logic is_lsm(input insn_t insn);
		return get_opcode(insn) == OP_LSM;
	endfunction

	// interrupt / trap instruction, all unused bits zero
	function automatic insn_t make_int(input irq_lvl_t lvl, input cause_t cause);
		insn_t insn;
		insn = '0;
		insn[OPC_LSB +: $bits(opcode_t)] = OP_INT;
		insn[INT_LVL_LSB +: $bits(irq_lvl_t)] = lvl;
		insn[INT_CAUSE_LSB +: $bits(cause_t)] = cause;
		return insn;
	endfunction

endpackage

/* design/bundle_prep.sv */
// repairs the fetched bundle before it enters the slot registers
// holds the software-written code buffer used by EXEC instructions
// output is purely combinational and is sampled on the bundle load edge

`timescale 1ns/1ps

module bundle_prep
	import decode_pkg::*;
#(
	parameter int NSLOTS = 4
) (
	input  logic                     clk,
	input  logic                     rst,
	input  logic [NSLOTS*INSN_W-1:0] ic_bundle_i,
	input  ic_fault_t                ic_fault_i,
	input  irq_lvl_t                 irq_i,
	input  irq_lvl_t                 im_i,
	input  cause_t                   cause_i,
	input  logic                     int_commit_i,
	input  logic                     cb_we_i,
	input  cb_addr_t                 cb_addr_i,
	input  insn_t                    cb_data_i,
	output insn_t [NSLOTS-1:0]       prep_bundle_o,
	output logic                     freeze_o
);

	localparam int CB_DEPTH = 2 ** $bits(cb_addr_t);

	// code buffer, one instruction per entry
	insn_t code_buf [CB_DEPTH];

	// interrupt instruction for the pending irq
	insn_t int_insn;
	// cause for a fetch fault, valid when a fault is reported
	cause_t flt_cause;
	// fault trap replicated into every slot
	insn_t flt_insn;
	logic bundle_zero;
	logic fault_any;
	// bundle after the per-slot rules only
	insn_t [NSLOTS-1:0] slot_fix;

	// ============================================================
	// code buffer
	// ============================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < CB_DEPTH; i++) begin
				code_buf[i] <= NOP_INSN;
			end
		end
		else if (cb_we_i) begin
			code_buf[cb_addr_i] <= cb_data_i;
		end
	end

	// ============================================================
	// interrupt and fault detection
	// ============================================================

	// irq above the mask freezes fetch unless an int is already committing
	assign freeze_o = (irq_i > im_i) && !int_commit_i;

	assign int_insn = make_int(irq_i, cause_i);

	assign bundle_zero = (ic_bundle_i == '0);
	assign fault_any = (ic_fault_i != IC_NONE) || bundle_zero;

	always_comb begin
		case (ic_fault_i)
			IC_TLB: flt_cause = FLT_TLB;
			IC_EXF: flt_cause = FLT_EXF;
			// bus error and the all-zero bundle share the ibe cause
			default: flt_cause = FLT_IBE;
		endcase
	end

	// traps carry level zero
	assign flt_insn = make_int('0, flt_cause);

	// ============================================================
	// per-slot rules
	// ============================================================

	always_comb begin : slot_rules
		insn_t raw;
		logic squash;
		squash = 1'b0;
		for (int s = 0; s < NSLOTS; s++) begin
			raw = ic_bundle_i[s*INSN_W +: INSN_W];
			if (squash) begin
				// slots behind a taken pfi never issue
				slot_fix[s] = NOP_INSN;
			end
			else if (is_pfi(raw)) begin
				if (irq_i == '0) begin
					slot_fix[s] = NOP_INSN;
				end
				else begin
					slot_fix[s] = int_insn;
					squash = 1'b1;
				end
			end
			else if (is_exec(raw)) begin
				// exec index selects a code buffer entry
				slot_fix[s] = code_buf[get_exec_idx(raw)];
			end
			else begin
				slot_fix[s] = raw;
			end
		end
	end

	// ============================================================
	// final priority
	// ============================================================

	always_comb begin
		for (int s = 0; s < NSLOTS; s++) begin
			if (freeze_o) begin
				prep_bundle_o[s] = int_insn;
			end
			else if (fault_any) begin
				prep_bundle_o[s] = flt_insn;
			end
			else begin
				prep_bundle_o[s] = slot_fix[s];
			end
		end
	end

endmodule

/* design/slot_buffer.sv */
// one instruction slot of the decode buffer
// loads its own entry of the repaired bundle and retires or steps on issue

`timescale 1ns/1ps

module slot_buffer
	import decode_pkg::*;
#(
	parameter int NSLOTS = 4,
	parameter int SLOT = 0
) (
	input  logic               clk,
	input  logic               rst,
	input  logic               bundle_load_i,
	input  insn_t [NSLOTS-1:0] load_insn_i,
	input  logic [NSLOTS-1:0]  queued_i,
	input  logic               stop_string_i,
	output insn_t              insn_o
);

	insn_t insn_q;
	// this slot's share of the load and issue vectors
	insn_t load_insn;
	logic queued;
	// load/store-multiple after one repeat
	insn_t step_insn;
	logic lsm_more;

	assign load_insn = load_insn_i[SLOT];
	assign queued = queued_i[SLOT];

	// ============================================================
	// lsm stepping
	// ============================================================

	// another repeat is due while the count is nonzero
	assign lsm_more = is_lsm(insn_q) && (get_lsm_cnt(insn_q) != '0);

	always_comb begin
		step_insn = insn_q;
		// register specs wrap at 32
		step_insn[RD_LSB +: $bits(reg_spec_t)] =
			insn_q[RD_LSB +: $bits(reg_spec_t)] + reg_spec_t'(1);
		step_insn[RS2_LSB +: $bits(reg_spec_t)] =
			insn_q[RS2_LSB +: $bits(reg_spec_t)] + reg_spec_t'(1);
		step_insn[CNT_LSB +: $bits(lsm_cnt_t)] = get_lsm_cnt(insn_q) - lsm_cnt_t'(1);
	end

	// ============================================================
	// slot register
	// ============================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			insn_q <= NOP_INSN;
		end
		else if (bundle_load_i) begin
			insn_q <= load_insn;
		end
		else if (queued) begin
			if (stop_string_i) begin
				// stop string kills the slot even mid-repeat
				insn_q <= NOP_INSN;
			end
			else if (lsm_more) begin
				insn_q <= step_insn;
			end
			else begin
				insn_q <= NOP_INSN;
			end
		end
	end

	assign insn_o = insn_q;

endmodule

/* design/issue_select.sv */
// picks the lowest live slot for issue and decides when to fetch
// no state; everything follows the slot registers and the input levels

`timescale 1ns/1ps

module issue_select
	import decode_pkg::*;
#(
	parameter int NSLOTS = 4
) (
	input  logic                      phit_i,
	input  logic                      queue_ready_i,
	input  insn_t [NSLOTS-1:0]        slot_insn_i,
	output logic                      bundle_load_o,
	output logic [NSLOTS-1:0]         queued_on_o,
	output logic                      fetch_o,
	output logic                      issue_valid_o,
	output insn_t                     issue_insn_o,
	output logic [$clog2(NSLOTS)-1:0] issue_slot_o
);

	logic [NSLOTS-1:0] live;
	logic any_live;
	// lowest live slot, one-hot and encoded
	logic [NSLOTS-1:0] pick_oh;
	logic [$clog2(NSLOTS)-1:0] pick_idx;

	always_comb begin
		for (int s = 0; s < NSLOTS; s++) begin
			live[s] = (slot_insn_i[s] != NOP_INSN);
		end
	end

	assign any_live = |live;

	// priority pick, scanning down so the lowest slot wins
	always_comb begin
		pick_oh = '0;
		pick_idx = '0;
		for (int s = NSLOTS - 1; s >= 0; s--) begin
			if (live[s]) begin
				pick_oh = '0;
				pick_oh[s] = 1'b1;
				pick_idx = s[$clog2(NSLOTS)-1:0];
			end
		end
	end

	// ============================================================
	// outputs
	// ============================================================

	// empty buffer asks for the next bundle and takes it on a hit
	assign fetch_o = !any_live;
	assign bundle_load_o = phit_i && !any_live;

	assign issue_valid_o = queue_ready_i && any_live;
	assign issue_insn_o = slot_insn_i[pick_idx];
	assign issue_slot_o = pick_idx;
	// only the issued slot retires or steps
	assign queued_on_o = issue_valid_o ? pick_oh : '0;

endmodule

/* design/decode_buffer_top.sv */
// decode buffer top level with bundle repair, slot registers and issue selection
// NSLOTS set here is passed down to every block

`timescale 1ns/1ps

module decode_buffer_top
	import decode_pkg::*;
#(
	parameter int NSLOTS = 4
) (
	input  logic                      clk,
	input  logic                      rst,
	input  logic [NSLOTS*INSN_W-1:0]  ic_bundle_i,
	input  ic_fault_t                 ic_fault_i,
	input  logic                      phit_i,
	input  irq_lvl_t                  irq_i,
	input  irq_lvl_t                  im_i,
	input  cause_t                    cause_i,
	input  logic                      int_commit_i,
	input  logic                      cb_we_i,
	input  cb_addr_t                  cb_addr_i,
	input  insn_t                     cb_data_i,
	input  logic                      stop_string_i,
	input  logic                      queue_ready_i,
	output logic                      freeze_o,
	output logic                      fetch_o,
	output logic                      issue_valid_o,
	output insn_t                     issue_insn_o,
	output logic [$clog2(NSLOTS)-1:0] issue_slot_o
);

	insn_t [NSLOTS-1:0] prep_bundle;
	insn_t [NSLOTS-1:0] slot_insn;
	logic bundle_load;
	logic [NSLOTS-1:0] queued_on;

	bundle_prep #(
		.NSLOTS(NSLOTS)
	) u_prep (
		.clk(clk),
		.rst(rst),
		.ic_bundle_i(ic_bundle_i),
		.ic_fault_i(ic_fault_i),
		.irq_i(irq_i),
		.im_i(im_i),
		.cause_i(cause_i),
		.int_commit_i(int_commit_i),
		.cb_we_i(cb_we_i),
		.cb_addr_i(cb_addr_i),
		.cb_data_i(cb_data_i),
		.prep_bundle_o(prep_bundle),
		.freeze_o(freeze_o)
	);

	// each slot picks its own entry and its own issue bit
	for (genvar g = 0; g < NSLOTS; g++) begin : g_slot
		slot_buffer #(
			.NSLOTS(NSLOTS),
			.SLOT(g)
		) u_slot (
			.clk(clk),
			.rst(rst),
			.bundle_load_i(bundle_load),
			.load_insn_i(prep_bundle),
			.queued_i(queued_on),
			.stop_string_i(stop_string_i),
			.insn_o(slot_insn[g])
		);
	end

	issue_select #(
		.NSLOTS(NSLOTS)
	) u_issue (
		.phit_i(phit_i),
		.queue_ready_i(queue_ready_i),
		.slot_insn_i(slot_insn),
		.bundle_load_o(bundle_load),
		.queued_on_o(queued_on),
		.fetch_o(fetch_o),
		.issue_valid_o(issue_valid_o),
		.issue_insn_o(issue_insn_o),
		.issue_slot_o(issue_slot_o)
	);

endmodule

/* bench/tb_decode_buffer.sv */
// testbench for decode_buffer_top that loads bundles, models the repair rules and
// checks every issued instruction against a queue of expected issues

`timescale 1ns/1ps

module tb_decode_buffer
	import decode_pkg::*;
;
	localparam int NSLOTS = 4;
	localparam int SW = $clog2(NSLOTS);

	typedef insn_t [NSLOTS-1:0] bundle_t;
	typedef logic [SW-1:0] slot_idx_t;

	logic clk = 1'b0;
	logic rst;
	bundle_t ic_bundle_i;
	ic_fault_t ic_fault_i;
	logic phit_i;
	irq_lvl_t irq_i;
	irq_lvl_t im_i;
	cause_t cause_i;
	logic int_commit_i;
	logic cb_we_i;
	cb_addr_t cb_addr_i;
	insn_t cb_data_i;
	logic stop_string_i;
	logic queue_ready_i = 1'b0;
	logic freeze_o;
	logic fetch_o;
	logic issue_valid_o;
	insn_t issue_insn_o;
	slot_idx_t issue_slot_o;

	// expected issues in order with their slot
	insn_t exp_insn_q[$];
	slot_idx_t exp_slot_q[$];
	// mirror of the code buffer
	insn_t cb_model [32];
	logic gaps_on = 1'b0;
	int pushed = 0;
	int issued = 0;
	int trimmed = 0;
	int cycles = 0;

	decode_buffer_top #(
		.NSLOTS(NSLOTS)
	) dut0 (
		.clk(clk),
		.rst(rst),
		.ic_bundle_i(ic_bundle_i),
		.ic_fault_i(ic_fault_i),
		.phit_i(phit_i),
		.irq_i(irq_i),
		.im_i(im_i),
		.cause_i(cause_i),
		.int_commit_i(int_commit_i),
		.cb_we_i(cb_we_i),
		.cb_addr_i(cb_addr_i),
		.cb_data_i(cb_data_i),
		.stop_string_i(stop_string_i),
		.queue_ready_i(queue_ready_i),
		.freeze_o(freeze_o),
		.fetch_o(fetch_o),
		.issue_valid_o(issue_valid_o),
		.issue_insn_o(issue_insn_o),
		.issue_slot_o(issue_slot_o)
	);

	always #5 clk = ~clk;

	// ============================================================
	// compare tasks
	// ============================================================

	task automatic check_insn(input string name, input insn_t exp, input insn_t act);
		if (exp !== act) begin
			$display("ERR t=%0t %s expected %h actual %h", $time, name, exp, act);
			$display("sim failed");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	task automatic check_slot(input string name, input slot_idx_t exp, input slot_idx_t act);
		if (exp !== act) begin
			$display("ERR t=%0t %s expected %0d actual %0d", $time, name, exp, act);
			$display("sim failed");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (exp !== act) begin
			$display("ERR t=%0t %s expected %b actual %b", $time, name, exp, act);
			$display("sim failed");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	// ============================================================
	// reference model
	// ============================================================

	// interrupt layout with opcode, level at 11..8 and cause at 23..16
	function automatic insn_t build_int(input irq_lvl_t lvl, input cause_t cause);
		insn_t v;
		v = '0;
		v[5:0] = OP_INT;
		v[11:8] = lvl;
		v[23:16] = cause;
		return v;
	endfunction

	function automatic bundle_t model_bundle(input bundle_t raw, input ic_fault_t flt,
			input irq_lvl_t irq, input irq_lvl_t im, input logic commit, input cause_t cause);
		bundle_t res;
		cause_t fc;
		logic squash;
		squash = 1'b0;
		fc = (flt == 2'd1) ? FLT_TLB : (flt == 2'd2) ? FLT_EXF : FLT_IBE;
		for (int s = 0; s < NSLOTS; s++) begin
			if (irq > im && !commit) begin
				res[s] = build_int(irq, cause);
			end
			else if (flt != 2'd0 || raw == '0) begin
				res[s] = build_int(4'd0, fc);
			end
			else if (squash) begin
				res[s] = NOP_INSN;
			end
			else if (raw[s][5:0] == OP_BRK && raw[s][39:35] == FN_PFI) begin
				// poll taken only with an irq present
				res[s] = (irq == 4'd0) ? NOP_INSN : build_int(irq, cause);
				squash = (irq != 4'd0);
			end
			else if (raw[s][5:0] == OP_BMISC && raw[s][39:35] == FN_EXEC) begin
				res[s] = cb_model[raw[s][17:13]];
			end
			else begin
				res[s] = raw[s];
			end
		end
		return res;
	endfunction

	// queue one issue per live slot plus lsm repeats until the count is zero
	task automatic push_expected(input bundle_t exp);
		insn_t cur;
		for (int s = 0; s < NSLOTS; s++) begin
			cur = exp[s];
			if (cur != NOP_INSN) begin
				exp_insn_q.push_back(cur);
				exp_slot_q.push_back(slot_idx_t'(s));
				pushed++;
				while (cur[5:0] == OP_LSM && cur[27:23] != 5'd0) begin
					cur[12:8] = cur[12:8] + 5'd1;
					cur[22:18] = cur[22:18] + 5'd1;
					cur[27:23] = cur[27:23] - 5'd1;
					exp_insn_q.push_back(cur);
					exp_slot_q.push_back(slot_idx_t'(s));
					pushed++;
				end
			end
		end
	endtask

	// ============================================================
	// stimulus helpers
	// ============================================================

	// opcodes 0x10..0x1f carry no special meaning
	function automatic insn_t rand_plain();
		insn_t v;
		logic [31:0] lo;
		logic [31:0] hi;
		lo = $urandom;
		hi = $urandom;
		v = {hi[7:0], lo};
		v[5:0] = {2'b01, hi[11:8]};
		return v;
	endfunction

	function automatic insn_t make_lsm(input reg_spec_t rd, input reg_spec_t rs2,
			input logic [4:0] cnt);
		insn_t v;
		v = rand_plain();
		v[5:0] = OP_LSM;
		v[12:8] = rd;
		v[22:18] = rs2;
		v[27:23] = cnt;
		return v;
	endfunction

	function automatic insn_t make_exec(input cb_addr_t idx);
		insn_t v;
		v = rand_plain();
		v[5:0] = OP_BMISC;
		v[39:35] = FN_EXEC;
		v[17:13] = idx;
		return v;
	endfunction

	function automatic insn_t make_pfi();
		insn_t v;
		v = rand_plain();
		v[5:0] = OP_BRK;
		v[39:35] = FN_PFI;
		return v;
	endfunction

	function automatic bundle_t rand_bundle();
		bundle_t b;
		for (int s = 0; s < NSLOTS; s++) begin
			b[s] = rand_plain();
		end
		return b;
	endfunction

	task automatic wait_empty();
		@(negedge clk);
		while (exp_insn_q.size() != 0 || !fetch_o) begin
			@(negedge clk);
		end
	endtask

	task automatic write_code_buf(input cb_addr_t addr, input insn_t data);
		@(posedge clk);
		cb_we_i <= 1'b1;
		cb_addr_i <= addr;
		cb_data_i <= data;
		@(posedge clk);
		cb_we_i <= 1'b0;
		cb_model[addr] = data;
	endtask

	// present a bundle on a hit; the load edge is one cycle later
	task automatic present_bundle(input bundle_t raw, input ic_fault_t flt,
			input irq_lvl_t irq, input irq_lvl_t im, input logic commit, input cause_t cause);
		bundle_t exp;
		wait_empty();
		exp = model_bundle(raw, flt, irq, im, commit, cause);
		@(posedge clk);
		ic_bundle_i <= raw;
		ic_fault_i <= flt;
		irq_i <= irq;
		im_i <= im;
		int_commit_i <= commit;
		cause_i <= cause;
		phit_i <= 1'b1;
		@(negedge clk);
		check_bit("freeze_o", irq > im && !commit, freeze_o);
		@(posedge clk);
		phit_i <= 1'b0;
		push_expected(exp);
	endtask

	// ============================================================
	// ready gaps, compare and timeout
	// ============================================================

	always @(posedge clk) begin
		if (rst) begin
			queue_ready_i <= 1'b0;
		end
		else if (gaps_on) begin
			queue_ready_i <= ($urandom_range(3, 0) != 0);
		end
		else begin
			queue_ready_i <= 1'b1;
		end
	end

	// outputs are stable at the falling edge
	always @(negedge clk) begin : compare
		insn_t exp_i;
		slot_idx_t exp_s;
		if (!rst) begin
			check_bit("fetch_o", exp_insn_q.size() == 0, fetch_o);
			check_bit("issue_valid_o", queue_ready_i && exp_insn_q.size() != 0, issue_valid_o);
			if (issue_valid_o) begin
				exp_i = exp_insn_q.pop_front();
				exp_s = exp_slot_q.pop_front();
				check_insn("issue_insn_o", exp_i, issue_insn_o);
				check_slot("issue_slot_o", exp_s, issue_slot_o);
				issued++;
				// stop string drops the remaining repeats of this slot
				while (stop_string_i && exp_slot_q.size() != 0 && exp_slot_q[0] == exp_s) begin
					void'(exp_insn_q.pop_front());
					void'(exp_slot_q.pop_front());
					trimmed++;
				end
			end
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles > 4 * pushed + 200) begin
			$display("timeout: run did not finish within %0d cycles", cycles);
			$display("sim failed");
			$fatal(1, "timeout");
		end
	end

	// ============================================================
	// test sequence
	// ============================================================

	initial begin
		bundle_t b;
		void'($urandom(32'h3e82));
		for (int i = 0; i < 32; i++) begin
			cb_model[i] = NOP_INSN;
		end
		rst = 1'b1;
		ic_bundle_i = '0;
		ic_fault_i = 2'd0;
		phit_i = 1'b0;
		irq_i = 4'd0;
		im_i = 4'd0;
		cause_i = 8'd0;
		int_commit_i = 1'b0;
		cb_we_i = 1'b0;
		cb_addr_i = 5'd0;
		cb_data_i = '0;
		stop_string_i = 1'b0;
		repeat (8) @(posedge clk);
		rst <= 1'b0;
		gaps_on <= 1'b1;

		// plain bundles in slot order with random ready gaps
		for (int n = 0; n < 20; n++) begin
			present_bundle(rand_bundle(), 2'd0, 4'd0, 4'd0, 1'b0, 8'd0);
		end

		// lsm in slot 1 with rs2 wrapping past 31
		b = rand_bundle();
		b[1] = make_lsm(5'd4, 5'd30, 5'd3);
		present_bundle(b, 2'd0, 4'd0, 4'd0, 1'b0, 8'd0);

		// exec entries from the code buffer and a pfi without irq
		write_code_buf(5'd7, rand_plain());
		write_code_buf(5'd20, make_lsm(5'd1, 5'd2, 5'd2));
		b = rand_bundle();
		b[0] = make_exec(5'd7);
		b[1] = make_pfi();
		b[2] = make_exec(5'd20);
		present_bundle(b, 2'd0, 4'd0, 4'd0, 1'b0, 8'd0);

		// pfi with irq below the mask squashes the later slots
		b = rand_bundle();
		b[1] = make_pfi();
		present_bundle(b, 2'd0, 4'd3, 4'd5, 1'b0, 8'h44);

		// fetch faults and the all-zero bundle
		present_bundle(rand_bundle(), 2'd1, 4'd0, 4'd0, 1'b0, 8'd0);
		present_bundle(rand_bundle(), 2'd2, 4'd0, 4'd0, 1'b0, 8'd0);
		present_bundle(rand_bundle(), 2'd3, 4'd0, 4'd0, 1'b0, 8'd0);
		present_bundle('0, 2'd0, 4'd0, 4'd0, 1'b0, 8'd0);

		// irq above mask freezes unless an int is committing
		present_bundle(rand_bundle(), 2'd0, 4'd6, 4'd2, 1'b0, 8'h51);
		present_bundle(rand_bundle(), 2'd0, 4'd6, 4'd2, 1'b1, 8'h51);

		// stop string on the fourth issue of an lsm
		gaps_on <= 1'b0;
		b = rand_bundle();
		b[0] = make_lsm(5'd10, 5'd12, 5'd10);
		present_bundle(b, 2'd0, 4'd0, 4'd0, 1'b0, 8'd0);
		repeat (3) @(posedge clk);
		stop_string_i <= 1'b1;
		@(posedge clk);
		stop_string_i <= 1'b0;
		gaps_on <= 1'b1;

		wait_empty();
		repeat (4) @(posedge clk);
		// count 10 gives 11 issues and the stop on the 4th cuts the last 7
		if (trimmed != 7) begin
			$display("stop string dropped %0d lsm repeats instead of 7", trimmed);
			$display("sim failed");
			$fatal(1, "stop string");
		end
		else begin
			$display("sim passed");
			$finish;
		end
	end

endmodule

/* all.f */
design/decode_pkg.sv
design/bundle_prep.sv
design/slot_buffer.sv
design/issue_select.sv
design/decode_buffer_top.sv
bench/tb_decode_buffer.sv

/* Makefile */
# Verilator build and run for the decode buffer testbench
# override any variable on the command line, e.g. make run LOG=other.log

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= tb_decode_buffer
OBJ_DIR   ?= obj_dir
FILELIST  ?= all.f
LOG       ?= sim.log

SRCS := $(wildcard design/*.sv bench/*.sv)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the log decides pass or fail
run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "sim passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
